// ==== common/jag_glue_pkg.sv ====
//======================================================================
// jaguar glue package
// shared widths, DDR window constants, download indices, BIOS patch
// values and the DDR command and host download structs
//======================================================================
package jag_glue_pkg;

	//==================================================================
	// widths with a meaning
	//==================================================================
	typedef logic [28:0] ddr_addr_t;   // 64-bit word address
	typedef logic [7:0]  ddr_be_t;
	typedef logic [63:0] ddr_data_t;
	typedef logic [23:0] abus_t;       // core byte address
	typedef logic [15:0] dl_word_t;
	typedef logic [24:0] dl_addr_t;    // download byte address
	typedef logic [31:0] cart_word_t;
	typedef logic [9:0]  bram_addr_t;
	typedef logic [15:0] bram_word_t;

	// command toward the DDR controller
	typedef struct packed {
		logic      rd;
		logic      we;
		ddr_addr_t addr;
		ddr_be_t   be;
		ddr_data_t din;
	} ddr_cmd_t;

	// host download bus
	typedef struct packed {
		logic       download;
		logic       wr;
		logic [7:0] index;
		dl_addr_t   addr;
		dl_word_t   data;
	} dl_bus_t;

	localparam logic [7:0] DDR_REGION     = 8'h30;        // jaguar window in DDR
	localparam abus_t      CART_LOAD_BASE = 24'h80_0000;  // cart lives at 8 MiB
	localparam logic [7:0] IDX_CART       = 8'd1;
	localparam logic [7:0] IDX_BIOS_A     = 8'd0;
	localparam logic [7:0] IDX_BIOS_B     = 8'd2;

	// checksum branch in the boot rom, beq turned into bra
	localparam abus_t      BIOS_PATCH_ADDR = 24'h00_136E;
	localparam logic [7:0] BIOS_PATCH_BYTE = 8'h60;

	typedef enum logic [1:0] {
		BK_IDLE,
		BK_XFER,          // request out, waiting for ack
		BK_WAIT_ACK_END   // sector streaming
	} bk_state_e;

endpackage

// ==== cart/cart_loader.sv ====
//======================================================================
// cartridge loader
// one byte-swapped, single-lane DDR write per 16-bit download word,
// with host wait held until the write is taken
//======================================================================
`timescale 1ns/1ps

module cart_loader (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  jag_glue_pkg::dl_bus_t  dl,
	input  logic                   ddr_busy,
	output logic                   loader_en,
	output jag_glue_pkg::ddr_cmd_t loader_cmd,
	output logic                   ioctl_wait
);
	import jag_glue_pkg::*;

	logic     cart_dl;     // cart download in progress
	logic     old_dl;
	logic     wr_pend;     // write waiting for a free DDR cycle
	logic     wr_accept;
	abus_t    load_addr;   // byte address of the next word
	dl_word_t wr_data;
	dl_word_t data_bs;

	assign cart_dl   = dl.download && (dl.index == IDX_CART);
	assign wr_accept = wr_pend && !ddr_busy;
	assign data_bs   = {wr_data[7:0], wr_data[15:8]};  // byte swap for DDR order

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_dl    <= 1'b0;
			loader_en <= 1'b0;
			wr_pend   <= 1'b0;
			load_addr <= CART_LOAD_BASE;
		end else begin
			old_dl <= cart_dl;
			if (!old_dl && cart_dl) begin  // download starts
				loader_en <= 1'b1;
				load_addr <= CART_LOAD_BASE;
			end
			if (old_dl && !cart_dl)
				loader_en <= 1'b0;

			if (dl.wr && cart_dl)
				wr_pend <= 1'b1;
			else if (wr_accept) begin
				wr_pend   <= 1'b0;
				load_addr <= load_addr + 24'd2;  // one word per write
			end
		end
	end

	// word capture
	always_ff @(posedge clk_sys) begin
		if (dl.wr && cart_dl)
			wr_data <= dl.data;
	end

	//==================================================================
	// command toward the DDR port
	//==================================================================
	always_comb begin
		loader_cmd      = '0;
		loader_cmd.we   = wr_pend;
		loader_cmd.addr = {DDR_REGION, load_addr[23:3]};
		// k = addr[2:1] picks lanes 7-2k..6-2k, upper word first
		loader_cmd.be   = ddr_be_t'(8'hC0 >> {load_addr[2:1], 1'b0});
		loader_cmd.din  = {4{data_bs}};
	end

	assign ioctl_wait = wr_pend;  // host stalls until the word is in DDR

	// host must honour ioctl_wait, one word in flight at most
	a_no_overrun: assert property (@(posedge clk_sys) disable iff (reset)
		(dl.wr && cart_dl) |-> !wr_pend);

endmodule

// ==== cart/cart_ddr_port.sv ====
//======================================================================
// cartridge DDR port
// fetch reads from core cart accesses, loader writes muxed in front,
// selected 32-bit half returned to the core
//======================================================================
`timescale 1ns/1ps

module cart_ddr_port (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     loader_en,
	input  jag_glue_pkg::ddr_cmd_t   loader_cmd,
	input  jag_glue_pkg::abus_t      abus,
	input  logic                     cart_ce_n,
	output jag_glue_pkg::ddr_cmd_t   ddr_cmd,
	input  logic                     ddr_busy,
	input  jag_glue_pkg::ddr_data_t  ddr_dout,
	input  logic                     ddr_dout_ready,
	output jag_glue_pkg::cart_word_t cart_q
);
	import jag_glue_pkg::*;

	abus_t old_abus;
	logic  old_ce_n;
	logic  rd_trig;   // new cart access this cycle
	logic  rd_pend;   // read held until DDR takes it
	abus_t rd_addr;

	// ce falling, or address moving while selected
	assign rd_trig = !cart_ce_n && (old_ce_n || (abus != old_abus));

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_ce_n <= 1'b1;
			old_abus <= '0;
			rd_pend  <= 1'b0;
		end else begin
			old_ce_n <= cart_ce_n;
			old_abus <= abus;
			if (rd_trig)
				rd_pend <= 1'b1;
			else if (rd_pend && !ddr_busy && !loader_en)  // accepted
				rd_pend <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rd_trig)
			rd_addr <= abus;
		if (ddr_dout_ready)
			cart_q <= abus[2] ? ddr_dout[31:0] : ddr_dout[63:32];  // even long is high half
	end

	//==================================================================
	// DDR mux, loader owns the port during a load
	//==================================================================
	always_comb begin
		if (loader_en)
			ddr_cmd = loader_cmd;
		else begin
			ddr_cmd      = '0;
			ddr_cmd.rd   = rd_pend;
			ddr_cmd.addr = {DDR_REGION, rd_addr[23:3]};
			ddr_cmd.be   = '1;  // controller wants all lanes on reads
		end
	end

	// a loader write under busy keeps address and data until taken
	a_wr_hold: assert property (@(posedge clk_sys) disable iff (reset)
		(ddr_cmd.we && ddr_busy) |=>
			(ddr_cmd.we && $stable(ddr_cmd.addr) && $stable(ddr_cmd.din)));

endmodule

// ==== hdl/bios_rom.sv ====
//======================================================================
// BIOS byte store
// filled two bytes per download word over two cycles, read by the
// core address, with the cart checksum patch on the output
//======================================================================
`timescale 1ns/1ps

module bios_rom #(
	parameter int BIOS_ADDR_W = 17
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  jag_glue_pkg::dl_bus_t dl,
	input  jag_glue_pkg::abus_t   abus,
	input  logic                  patch_en,
	output logic [7:0]            bios_q
);
	import jag_glue_pkg::*;

	logic [7:0] mem [2**BIOS_ADDR_W];

	logic                   bios_dl;
	logic                   fill_lo;    // low byte due next edge
	logic                   fill_hi;    // then the high byte
	logic [BIOS_ADDR_W-2:0] fill_word;
	dl_word_t               fill_data;
	logic                   wr_en;
	logic [BIOS_ADDR_W-1:0] wr_addr;
	logic [7:0]             wr_byte;
	logic [BIOS_ADDR_W-1:0] rd_addr;    // registered read address
	logic [7:0]             rd_data;

	assign bios_dl = dl.download && (dl.index == IDX_BIOS_A || dl.index == IDX_BIOS_B);

	//==================================================================
	// two-phase fill
	//==================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			fill_lo <= 1'b0;
			fill_hi <= 1'b0;
		end else begin
			fill_lo <= bios_dl && dl.wr;
			fill_hi <= fill_lo;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (bios_dl && dl.wr) begin
			fill_word <= dl.addr[BIOS_ADDR_W-1:1];
			fill_data <= dl.data;
		end
	end

	assign wr_en   = fill_lo || fill_hi;
	assign wr_addr = {fill_word, fill_hi};                    // even then odd
	assign wr_byte = fill_hi ? fill_data[15:8] : fill_data[7:0];

	// inferred memory, separate read address
	always_ff @(posedge clk_sys) begin
		if (wr_en)
			mem[wr_addr] <= wr_byte;
		rd_addr <= abus[BIOS_ADDR_W-1:0];
		rd_data <= mem[abus[BIOS_ADDR_W-1:0]];
	end

	// beq -> bra, skips the cart checksum fail
	assign bios_q = (patch_en && rd_addr == BIOS_PATCH_ADDR[BIOS_ADDR_W-1:0]) ?
		BIOS_PATCH_BYTE : rd_data;

endmodule

// ==== backup/backup_ram.sv ====
//======================================================================
// backup RAM
// true dual-port 1024 x 16, port a for the core, port b for the SD
// sector buffer
//======================================================================
`timescale 1ns/1ps

module backup_ram (
	input  logic                     clk_sys,
	// core side
	input  jag_glue_pkg::bram_addr_t a_addr,
	input  jag_glue_pkg::bram_word_t a_data,
	input  logic                     a_wr,
	output jag_glue_pkg::bram_word_t a_q,
	// sector side
	input  jag_glue_pkg::bram_addr_t b_addr,
	input  jag_glue_pkg::bram_word_t b_data,
	input  logic                     b_wr,
	output jag_glue_pkg::bram_word_t b_q
);
	import jag_glue_pkg::*;

	bram_word_t mem [1024];

	// port a, read-first
	always @(posedge clk_sys) begin
		if (a_wr)
			mem[a_addr] <= a_data;
		a_q <= mem[a_addr];  // one-cycle latency
	end

	// port b
	always @(posedge clk_sys) begin
		if (b_wr)
			mem[b_addr] <= b_data;
		b_q <= mem[b_addr];
	end

endmodule

// ==== backup/backup_sync.sv ====
//======================================================================
// backup sequencer
// backup enable on image mount, pending-write tracking and the SD
// sector load and save machine
//======================================================================
`timescale 1ns/1ps

module backup_sync #(
	parameter int BK_SECTORS = 4
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  jag_glue_pkg::dl_bus_t dl,
	input  logic                  img_mounted,
	input  logic                  img_readonly,
	input  logic                  bram_wr,
	input  logic                  osd_open,
	input  logic                  bk_load_req,
	input  logic                  bk_save_req,
	input  logic                  autosave_en,
	output logic [31:0]           sd_lba,
	output logic                  sd_rd,
	output logic                  sd_wr,
	input  logic                  sd_ack,
	input  logic                  sd_buff_wr,
	output logic                  ram_b_wr,
	output logic                  bk_busy,
	output logic                  bk_pending
);
	import jag_glue_pkg::*;

	localparam logic [31:0] LAST_LBA = 32'(BK_SECTORS - 1);

	bk_state_e state;
	logic      bk_ena;       // save file mounted and writable
	logic      bk_loading;   // direction of the running transfer
	logic      old_dl, old_load, old_save, old_ack;
	logic      cart_dl;
	logic      bk_save;
	logic      start_load, start_save;
	logic      ack_rise, ack_fall;

	assign cart_dl    = dl.download && (dl.index == IDX_CART);
	assign bk_save    = bk_save_req || (bk_pending && osd_open && autosave_en);  // menu autosave
	assign start_load = (!old_load && bk_load_req) || (old_dl && !cart_dl);    // manual or end of load
	assign start_save = !old_save && bk_save;
	assign ack_rise   = !old_ack && sd_ack;
	assign ack_fall   = old_ack && !sd_ack;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= BK_IDLE;
			bk_ena     <= 1'b0;
			bk_loading <= 1'b0;
			bk_pending <= 1'b0;
			old_dl     <= 1'b0;
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
		end else begin
			old_dl   <= cart_dl;
			old_load <= bk_load_req;
			old_save <= bk_save;
			old_ack  <= sd_ack;

			if (!old_dl && cart_dl)
				bk_ena <= 1'b0;  // new cart, forget old save
			if (cart_dl && img_mounted && !img_readonly)
				bk_ena <= 1'b1;  // save file mounts during the download
			if (bk_ena && !osd_open && bram_wr)
				bk_pending <= 1'b1;

			//==========================================================
			// sector machine
			//==========================================================
			case (state)
				BK_IDLE: begin
					if (bk_ena && (start_load || start_save)) begin
						state      <= BK_XFER;
						bk_loading <= start_load;  // load wins over save
						sd_lba     <= '0;
						sd_rd      <= start_load;
						sd_wr      <= !start_load;
					end
				end
				BK_XFER: begin
					if (ack_rise) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= BK_WAIT_ACK_END;
					end
				end
				BK_WAIT_ACK_END: begin
					if (ack_fall) begin
						if (sd_lba == LAST_LBA) begin  // last sector done
							state      <= BK_IDLE;
							sd_lba     <= '0;
							bk_pending <= 1'b0;
						end else begin
							state  <= BK_XFER;
							sd_lba <= sd_lba + 32'd1;
							sd_rd  <= bk_loading;
							sd_wr  <= !bk_loading;
						end
					end
				end
				default: state <= BK_IDLE;
			endcase
		end
	end

	assign bk_busy  = (state != BK_IDLE);
	// sector data lands only inside the backup window
	assign ram_b_wr = sd_ack && sd_buff_wr && (sd_lba < 32'(BK_SECTORS));

	// SD host acks only an outstanding request
	a_ack_on_req: assert property (@(posedge clk_sys) disable iff (reset)
		ack_rise |-> (state == BK_XFER));

endmodule

// ==== hdl/jag_glue_top.sv ====
//======================================================================
// jaguar host glue top
// cartridge loader and fetch over DDR, BIOS store, backup RAM and the
// backup sector sequencer
//======================================================================
`timescale 1ns/1ps

module jag_glue_top #(
	parameter int BIOS_ADDR_W = 17,
	parameter int BK_SECTORS  = 4
) (
	input  logic                    clk_sys,
	input  logic                    reset,
	// host download
	input  jag_glue_pkg::dl_bus_t   dl,
	output logic                    ioctl_wait,
	input  logic                    patch_en,
	output logic                    core_reset,
	// core bus
	input  jag_glue_pkg::abus_t     abus,
	input  logic                    cart_ce_n,
	output jag_glue_pkg::cart_word_t cart_q,
	output logic [7:0]              bios_q,
	// DDR
	output jag_glue_pkg::ddr_cmd_t  ddr_cmd,
	input  logic                    ddr_busy,
	input  jag_glue_pkg::ddr_data_t ddr_dout,
	input  logic                    ddr_dout_ready,
	// core backup port
	input  jag_glue_pkg::bram_addr_t bram_addr,
	input  jag_glue_pkg::bram_word_t bram_data,
	input  logic                    bram_wr,
	output jag_glue_pkg::bram_word_t bram_q,
	// menu and backup control
	input  logic                    osd_open,
	input  logic                    bk_load_req,
	input  logic                    bk_save_req,
	input  logic                    autosave_en,
	input  logic                    img_mounted,
	input  logic                    img_readonly,
	// SD sector port
	output logic [31:0]             sd_lba,
	output logic                    sd_rd,
	output logic                    sd_wr,
	input  logic                    sd_ack,
	input  logic [7:0]              sd_buff_addr,
	input  jag_glue_pkg::bram_word_t sd_buff_dout,
	input  logic                    sd_buff_wr,
	output jag_glue_pkg::bram_word_t sd_buff_din,
	output logic                    bk_busy,
	output logic                    bk_pending
);
	import jag_glue_pkg::*;

	localparam int LBA_W = $clog2(BK_SECTORS);  // sector bits in the backup address

	ddr_cmd_t loader_cmd;
	logic     loader_en;
	logic     ram_b_wr;

	assign core_reset = reset | dl.download;  // core held during any download

	//==================================================================
	// cartridge path
	//==================================================================
	cart_loader u_cart_loader (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl         (dl),
		.ddr_busy   (ddr_busy),
		.loader_en  (loader_en),
		.loader_cmd (loader_cmd),
		.ioctl_wait (ioctl_wait)
	);

	cart_ddr_port u_cart_ddr_port (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.loader_en      (loader_en),
		.loader_cmd     (loader_cmd),
		.abus           (abus),
		.cart_ce_n      (cart_ce_n),
		.ddr_cmd        (ddr_cmd),
		.ddr_busy       (ddr_busy),
		.ddr_dout       (ddr_dout),
		.ddr_dout_ready (ddr_dout_ready),
		.cart_q         (cart_q)
	);

	bios_rom #(.BIOS_ADDR_W(BIOS_ADDR_W)) u_bios_rom (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl       (dl),
		.abus     (abus),
		.patch_en (patch_en),
		.bios_q   (bios_q)
	);

	//==================================================================
	// backup
	//==================================================================
	backup_ram u_backup_ram (
		.clk_sys (clk_sys),
		.a_addr  (bram_addr),
		.a_data  (bram_data),
		.a_wr    (bram_wr),
		.a_q     (bram_q),
		.b_addr  (bram_addr_t'({sd_lba[LBA_W-1:0], sd_buff_addr})),  // sector:word
		.b_data  (sd_buff_dout),
		.b_wr    (ram_b_wr),
		.b_q     (sd_buff_din)
	);

	backup_sync #(.BK_SECTORS(BK_SECTORS)) u_backup_sync (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl           (dl),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.bram_wr      (bram_wr),
		.osd_open     (osd_open),
		.bk_load_req  (bk_load_req),
		.bk_save_req  (bk_save_req),
		.autosave_en  (autosave_en),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.sd_ack       (sd_ack),
		.sd_buff_wr   (sd_buff_wr),
		.ram_b_wr     (ram_b_wr),
		.bk_busy      (bk_busy),
		.bk_pending   (bk_pending)
	);

endmodule

// ==== tests/jag_glue_vectors.svh ====
//======================================================================
// jaguar glue test vectors
// operation, address, data and expected value per row
//======================================================================
`ifndef JAG_GLUE_VECTORS_SVH
`define JAG_GLUE_VECTORS_SVH

localparam logic [3:0] OP_DL_START = 4'd0;   // addr = download index
localparam logic [3:0] OP_DL_END   = 4'd1;
localparam logic [3:0] OP_CART_WR  = 4'd2;   // addr = byte offset in cart
localparam logic [3:0] OP_FETCH    = 4'd3;   // exp = cart_q
localparam logic [3:0] OP_BIOS_WR  = 4'd4;
localparam logic [3:0] OP_BIOS_RD  = 4'd5;   // data = patch_en
localparam logic [3:0] OP_MOUNT    = 4'd6;
localparam logic [3:0] OP_BK_WAIT  = 4'd7;   // data = direction, exp = sectors
localparam logic [3:0] OP_BRAM_RD  = 4'd8;   // expected from the SD pattern
localparam logic [3:0] OP_BRAM_WR  = 4'd9;
localparam logic [3:0] OP_CHK_PEND = 4'd10;
localparam logic [3:0] OP_OSD      = 4'd11;
localparam logic [3:0] OP_LOAD_REQ = 4'd12;  // exp = SD requests seen
localparam logic [3:0] OP_SAVED    = 4'd13;  // exp = word in saved sectors

typedef struct packed {
	logic [3:0]  op;
	logic [31:0] addr;
	logic [31:0] data;
	logic [31:0] exp;
} vec_row_t;

localparam int N_ROWS = 44;

// columns: op, addr, data, expected
vec_row_t vec_table [N_ROWS] = '{
	'{OP_LOAD_REQ, 32'h0, 32'h0, 32'h0},             // no mount yet
	'{OP_DL_START, 32'h0, 32'h0, 32'h0},
	'{OP_BIOS_WR,  32'h0000, 32'hBEEF, 32'h0},
	'{OP_BIOS_WR,  32'h136E, 32'h1234, 32'h0},
	'{OP_DL_END,   32'h0, 32'h0, 32'h0},
	'{OP_DL_START, 32'h2, 32'h0, 32'h0},
	'{OP_BIOS_WR,  32'h1000, 32'h5A3C, 32'h0},
	'{OP_DL_END,   32'h0, 32'h0, 32'h0},
	'{OP_BIOS_RD,  32'h0000, 32'h0, 32'hEF},
	'{OP_BIOS_RD,  32'h0001, 32'h0, 32'hBE},
	'{OP_BIOS_RD,  32'h136E, 32'h1, 32'h60},         // patched branch
	'{OP_BIOS_RD,  32'h136E, 32'h0, 32'h34},
	'{OP_BIOS_RD,  32'h136F, 32'h1, 32'h12},
	'{OP_BIOS_RD,  32'h1001, 32'h0, 32'h5A},
	'{OP_DL_START, 32'h1, 32'h0, 32'h0},             // cartridge
	'{OP_MOUNT,    32'h0, 32'h0, 32'h0},
	'{OP_CART_WR,  32'h0, 32'h1122, 32'h0},
	'{OP_CART_WR,  32'h2, 32'h3344, 32'h0},
	'{OP_CART_WR,  32'h4, 32'h5566, 32'h0},
	'{OP_CART_WR,  32'h6, 32'h7788, 32'h0},
	'{OP_CART_WR,  32'h8, 32'h99AA, 32'h0},
	'{OP_CART_WR,  32'hA, 32'hBBCC, 32'h0},
	'{OP_CART_WR,  32'hC, 32'hDDEE, 32'h0},
	'{OP_CART_WR,  32'hE, 32'hF001, 32'h0},
	'{OP_DL_END,   32'h0, 32'h0, 32'h0},             // auto backup load
	'{OP_BK_WAIT,  32'h0, 32'h0, 32'h4},
	'{OP_BRAM_RD,  32'h000, 32'h0, 32'h0},
	'{OP_BRAM_RD,  32'h1FF, 32'h0, 32'h0},
	'{OP_BRAM_RD,  32'h3FF, 32'h0, 32'h0},
	'{OP_FETCH,    32'h800000, 32'h0, 32'h22114433},
	'{OP_FETCH,    32'h800004, 32'h0, 32'h66558877},
	'{OP_FETCH,    32'h800008, 32'h0, 32'hAA99CCBB},
	'{OP_FETCH,    32'h80000C, 32'h0, 32'hEEDD01F0},
	'{OP_BRAM_WR,  32'h005, 32'h1357, 32'h0},
	'{OP_BRAM_WR,  32'h1FF, 32'h2468, 32'h0},
	'{OP_BRAM_WR,  32'h300, 32'hACE1, 32'h0},
	'{OP_CHK_PEND, 32'h0, 32'h0, 32'h1},
	'{OP_OSD,      32'h0, 32'h1, 32'h0},             // menu opens, autosave
	'{OP_BK_WAIT,  32'h0, 32'h1, 32'h4},
	'{OP_SAVED,    32'h005, 32'h0, 32'h1357},
	'{OP_SAVED,    32'h1FF, 32'h0, 32'h2468},
	'{OP_SAVED,    32'h300, 32'h0, 32'hACE1},
	'{OP_CHK_PEND, 32'h0, 32'h0, 32'h0},
	'{OP_OSD,      32'h0, 32'h0, 32'h0}
};

`endif

// ==== tests/jag_glue_tb.sv ====
//======================================================================
// jaguar glue testbench
// DDR and SD models around the glue top, table-driven stimulus
//======================================================================
`timescale 1ns/1ps

module jag_glue_tb;
	import jag_glue_pkg::*;
	`include "jag_glue_vectors.svh"

	logic clk_sys, reset;
	dl_bus_t dl;
	logic ioctl_wait, patch_en, core_reset;
	abus_t abus;
	logic cart_ce_n;
	cart_word_t cart_q;
	logic [7:0] bios_q;
	ddr_cmd_t ddr_cmd;
	logic ddr_busy, ddr_dout_ready;
	ddr_data_t ddr_dout;
	bram_addr_t bram_addr;
	bram_word_t bram_data, bram_q, sd_buff_dout, sd_buff_din;
	logic bram_wr, osd_open, bk_load_req, bk_save_req, autosave_en;
	logic img_mounted, img_readonly;
	logic [31:0] sd_lba;
	logic sd_rd, sd_wr, sd_ack, sd_buff_wr, bk_busy, bk_pending;
	logic [7:0] sd_buff_addr;

	int mismatch_cnt = 0;
	int fail_cnt = 0;
	int cycles = 0;
	logic [31:0] lfsr = 32'h63d0da3e;

	ddr_data_t ddr_mem [ddr_addr_t];
	ddr_cmd_t ddr_wr_log [$];     // accepted writes
	int rd_wait;
	ddr_data_t rd_word;
	logic [32:0] sd_log [$];      // {dir, lba} per request
	bram_word_t save_buf [1024];
	int sd_phase, sd_dly, sd_cnt;
	logic sd_dir;
	logic [31:0] sd_cur;

	jag_glue_top #(.BIOS_ADDR_W(17), .BK_SECTORS(4)) DUT (
		.clk_sys(clk_sys), .reset(reset), .dl(dl), .ioctl_wait(ioctl_wait),
		.patch_en(patch_en), .core_reset(core_reset), .abus(abus),
		.cart_ce_n(cart_ce_n), .cart_q(cart_q), .bios_q(bios_q),
		.ddr_cmd(ddr_cmd), .ddr_busy(ddr_busy), .ddr_dout(ddr_dout),
		.ddr_dout_ready(ddr_dout_ready), .bram_addr(bram_addr),
		.bram_data(bram_data), .bram_wr(bram_wr), .bram_q(bram_q),
		.osd_open(osd_open), .bk_load_req(bk_load_req), .bk_save_req(bk_save_req),
		.autosave_en(autosave_en), .img_mounted(img_mounted),
		.img_readonly(img_readonly), .sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr),
		.sd_ack(sd_ack), .sd_buff_addr(sd_buff_addr), .sd_buff_dout(sd_buff_dout),
		.sd_buff_wr(sd_buff_wr), .sd_buff_din(sd_buff_din), .bk_busy(bk_busy),
		.bk_pending(bk_pending)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// galois lfsr, low bit is the bit taken
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// sd image contents, depends on sector and word
	function automatic bram_word_t sector_word(input logic [9:0] a);
		return (16'(a) * 16'h0107) ^ 16'hA55A;
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		$display("MISMATCH %s got %h expected %h", name, got, exp);
		mismatch_cnt++;
	endtask

	//==================================================================
	// DDR model
	//==================================================================
	always @(posedge clk_sys) begin : ddr_model
		ddr_data_t w;
		if (reset) begin
			ddr_busy       <= 1'b0;
			ddr_dout_ready <= 1'b0;
			rd_wait        <= 0;
			rd_word        <= '0;
		end else begin
			ddr_busy <= lfsr[0];   // one bit per cycle
			lfsr     <= lfsr_step(lfsr);
			if (ddr_cmd.we && !ddr_busy) begin
				w = ddr_mem.exists(ddr_cmd.addr) ? ddr_mem[ddr_cmd.addr] : '0;
				for (int b = 0; b < 8; b++)
					if (ddr_cmd.be[b])
						w[8*b +: 8] = ddr_cmd.din[8*b +: 8];
				ddr_mem[ddr_cmd.addr] = w;
				ddr_wr_log.push_back(ddr_cmd);
			end
			if (ddr_cmd.rd && !ddr_busy) begin
				if (dl.download && dl.index == IDX_CART) begin
					$display("DDR read issued during a cartridge load");
					fail_cnt++;
				end
				rd_word <= ddr_mem.exists(ddr_cmd.addr) ? ddr_mem[ddr_cmd.addr] : '0;
				rd_wait <= 4;
			end else if (rd_wait > 0)
				rd_wait <= rd_wait - 1;
			ddr_dout_ready <= (rd_wait == 1);  // four cycles after accept
			ddr_dout       <= rd_word;
		end
	end

	//==================================================================
	// SD model, 256 words per sector while ack is high
	//==================================================================
	always @(posedge clk_sys) begin : sd_model
		if (reset) begin
			sd_phase   <= 0;
			sd_ack     <= 1'b0;
			sd_buff_wr <= 1'b0;
		end else case (sd_phase)
			0: if (sd_rd || sd_wr) begin
				sd_dir <= sd_wr;
				sd_cur <= sd_lba;
				sd_log.push_back({sd_wr, sd_lba});
				sd_dly   <= 3;
				sd_phase <= 1;
			end
			1: if (sd_dly == 1) begin
				sd_ack   <= 1'b1;
				sd_cnt   <= 0;
				sd_phase <= 2;
			end else
				sd_dly <= sd_dly - 1;
			default: begin
				if (sd_cnt < 256) begin
					sd_buff_addr <= 8'(sd_cnt);
					sd_buff_dout <= sector_word({sd_cur[1:0], 8'(sd_cnt)});
					sd_buff_wr   <= !sd_dir;
				end else
					sd_buff_wr <= 1'b0;
				if (sd_dir && sd_cnt >= 2)  // read port lags two edges
					save_buf[{sd_cur[1:0], 8'(sd_cnt - 2)}] <= sd_buff_din;
				sd_cnt <= sd_cnt + 1;
				if (sd_cnt == 257) begin
					sd_ack   <= 1'b0;
					sd_phase <= 0;
				end
			end
		endcase
	end

	// run limit
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles > N_ROWS * 600) begin
			$display("timeout after %0d cycles", cycles);
			$display("Test failed");
			$finish;
		end
	end

	//==================================================================
	// row application
	//==================================================================
	task automatic apply_row(input vec_row_t r);
		ddr_cmd_t wcmd;
		ddr_be_t e_be;
		dl_word_t sw;
		abus_t ba;
		int k;
		case (r.op)
			OP_DL_START, OP_DL_END: begin
				@(posedge clk_sys);
				dl.download <= (r.op == OP_DL_START);
				if (r.op == OP_DL_START)
					dl.index <= r.addr[7:0];
				repeat (2) @(posedge clk_sys);
				@(negedge clk_sys);
				if (core_reset !== (r.op == OP_DL_START))  // core held while downloading
					report_mismatch("core_reset", core_reset, r.op == OP_DL_START);
			end
			OP_CART_WR, OP_BIOS_WR: begin
				@(posedge clk_sys);
				dl.wr   <= 1'b1;
				dl.addr <= dl_addr_t'(r.addr);
				dl.data <= r.data[15:0];
				if (r.op == OP_CART_WR) begin
					abus      <= CART_LOAD_BASE + abus_t'(r.addr);  // core tries a fetch mid-load
					cart_ce_n <= 1'b0;
				end
				@(posedge clk_sys);
				dl.wr     <= 1'b0;
				cart_ce_n <= 1'b1;
				@(negedge clk_sys);
				while (ioctl_wait)
					@(negedge clk_sys);
				repeat (2) @(posedge clk_sys);  // bios fill takes two edges
				if (r.op == OP_CART_WR) begin
					if (ddr_wr_log.size() != 1) begin
						$display("word at offset %h gave %0d DDR writes instead of one",
							r.addr, ddr_wr_log.size());
						fail_cnt++;
					end else begin
						wcmd = ddr_wr_log.pop_front();
						ba   = CART_LOAD_BASE + abus_t'(r.addr);
						k    = ba[2:1];
						e_be = '0;
						e_be[7 - 2*k] = 1'b1;
						e_be[6 - 2*k] = 1'b1;
						sw = {r.data[7:0], r.data[15:8]};
						if (wcmd.addr !== {DDR_REGION, ba[23:3]})
							report_mismatch("ddr_cmd.addr", wcmd.addr, {DDR_REGION, ba[23:3]});
						if (wcmd.be !== e_be)
							report_mismatch("ddr_cmd.be", wcmd.be, e_be);
						if (wcmd.din !== {4{sw}})
							report_mismatch("ddr_cmd.din", wcmd.din, {4{sw}});
					end
					ddr_wr_log.delete();
				end
			end
			OP_FETCH: begin
				@(posedge clk_sys);
				abus      <= r.addr[23:0];
				cart_ce_n <= 1'b0;
				@(negedge clk_sys);
				while (!ddr_dout_ready)
					@(negedge clk_sys);
				@(negedge clk_sys);
				if (cart_q !== r.exp)
					report_mismatch("cart_q", cart_q, r.exp);
				@(posedge clk_sys);
				cart_ce_n <= 1'b1;
				@(posedge clk_sys);
			end
			OP_BIOS_RD: begin
				@(posedge clk_sys);
				abus     <= r.addr[23:0];
				patch_en <= r.data[0];
				repeat (2) @(posedge clk_sys);
				@(negedge clk_sys);
				if (bios_q !== r.exp[7:0])
					report_mismatch("bios_q", bios_q, r.exp[7:0]);
			end
			OP_MOUNT: begin
				@(posedge clk_sys);
				img_mounted <= 1'b1;
				@(posedge clk_sys);
				img_mounted <= 1'b0;
			end
			OP_BK_WAIT: begin
				repeat (3) @(negedge clk_sys);
				while (bk_busy)
					@(negedge clk_sys);
				if (sd_log.size() != r.exp)
					report_mismatch("sd request count", sd_log.size(), r.exp);
				for (int i = 0; i < sd_log.size(); i++)
					if (sd_log[i] !== {r.data[0], 32'(i)})
						report_mismatch("sd request {dir,lba}", sd_log[i], {r.data[0], 32'(i)});
				sd_log.delete();
			end
			OP_BRAM_RD: begin
				@(posedge clk_sys);
				bram_addr <= r.addr[9:0];
				repeat (2) @(posedge clk_sys);
				@(negedge clk_sys);
				if (bram_q !== sector_word(r.addr[9:0]))
					report_mismatch("bram_q", bram_q, sector_word(r.addr[9:0]));
			end
			OP_BRAM_WR: begin
				@(posedge clk_sys);
				bram_addr <= r.addr[9:0];
				bram_data <= r.data[15:0];
				bram_wr   <= 1'b1;
				@(posedge clk_sys);
				bram_wr <= 1'b0;
			end
			OP_CHK_PEND: begin
				@(negedge clk_sys);
				if (bk_pending !== r.exp[0])
					report_mismatch("bk_pending", bk_pending, r.exp[0]);
				if (bk_busy !== 1'b0)
					report_mismatch("bk_busy", bk_busy, 1'b0);
			end
			OP_OSD: begin
				@(posedge clk_sys);
				osd_open <= r.data[0];
				@(posedge clk_sys);
			end
			OP_LOAD_REQ: begin
				@(posedge clk_sys);
				bk_load_req <= 1'b1;
				@(posedge clk_sys);
				bk_load_req <= 1'b0;
				repeat (20) @(posedge clk_sys);
				@(negedge clk_sys);
				if (sd_log.size() != r.exp) begin
					$display("load request without a mount gave %0d SD requests",
						sd_log.size());
					fail_cnt++;
				end
				if (bk_busy !== 1'b0)
					report_mismatch("bk_busy", bk_busy, 1'b0);
			end
			OP_SAVED: begin
				if (save_buf[r.addr[9:0]] !== r.exp[15:0])
					report_mismatch("sd_buff_din", save_buf[r.addr[9:0]], r.exp[15:0]);
			end
			default: begin
				$display("unknown table operation %0d", r.op);
				fail_cnt++;
			end
		endcase
	endtask

	initial begin
		reset          = 1'b1;
		dl             = '0;
		patch_en       = 1'b0;
		abus           = '0;
		cart_ce_n      = 1'b1;
		bram_addr      = '0;
		bram_data      = '0;
		bram_wr        = 1'b0;
		osd_open       = 1'b0;
		bk_load_req    = 1'b0;
		bk_save_req    = 1'b0;
		autosave_en    = 1'b1;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		sd_buff_addr   = '0;
		sd_buff_dout   = '0;
		sd_ack         = 1'b0;
		sd_buff_wr     = 1'b0;
		ddr_busy       = 1'b0;
		ddr_dout       = '0;
		ddr_dout_ready = 1'b0;
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;
		for (int i = 0; i < N_ROWS; i++)
			apply_row(vec_table[i]);
		repeat (5) @(posedge clk_sys);
		$display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
		if (mismatch_cnt == 0 && fail_cnt == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== build.f ====
common/jag_glue_pkg.sv
cart/cart_loader.sv
cart/cart_ddr_port.sv
hdl/bios_rom.sv
backup/backup_ram.sv
backup/backup_sync.sv
hdl/jag_glue_top.sv
+incdir+tests
tests/jag_glue_tb.sv
